//--- Makefile
# Verilator flow for the BLAKE2 compression engine

LOG := sim.log

.PHONY: all run lint clean

all: run

# Build, run, then decide on the log contents
run:
	verilator --binary -j 0 --top-module blake_tb -f project.f \
		--Mdir obj_dir -o blake_sim
	./obj_dir/blake_sim | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing --top-module blake_tb -f project.f

clean:
	rm -rf obj_dir $(LOG)

//--- bench/blake_model.sv
`default_nettype none

`include "blake_defs.svh"

module blake_model
    import blake_pkg::*;
(
    input  hash_mode_t mode,
    input  hvec_t      h_in,
    input  vvec_t      msg,
    input  word_t      offset,
    input  logic       last,
    output hvec_t      h_exp
);

    timeunit 1ns;
    timeprecision 1ps;

    // Message schedule, one row per round
    localparam int sigma_tab [10][16] = '{
        '{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
        '{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
        '{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
        '{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
        '{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
        '{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
        '{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
        '{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6,  2, 10},
        '{ 6, 15, 14,  9, 11,  3,  0,  8, 12,  2, 13,  7,  1,  4, 10,  5},
        '{10,  2,  8,  4,  7,  6,  1,  5, 15, 11,  9, 14,  3, 12, 13,  0}
    };

    // SHA-512 IV; its upper halves are the 32-bit IV
    localparam logic [63:0] iv [8] = '{
        64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b,
        64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
        64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
        64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
    };

    // Word arithmetic wraps at 32 bits in BLAKE2s
    function automatic word_t trim(input hash_mode_t md, input word_t x);
        return (md == MODE_2S) ? {32'h0, x[31:0]} : x;
    endfunction

    function automatic word_t rotr(input hash_mode_t md, input word_t x, input int n);
        logic [31:0] lo;
        lo = x[31:0];
        if (md == MODE_2S) begin
            return {32'h0, (lo >> n) | (lo << (32 - n))};
        end
        return (x >> n) | (x << (64 - n));
    endfunction

    // Full G step on four vector words with two message words
    function automatic vvec_t mix(input hash_mode_t md, input vvec_t v_in,
                                  input int a, input int b, input int c, input int d,
                                  input word_t x, input word_t y);
        vvec_t v;
        int    r1;
        int    r2;
        int    r3;
        int    r4;
        v  = v_in;
        r1 = (md == MODE_2S) ? `BLAKE_R1_2S : `BLAKE_R1_2B;
        r2 = (md == MODE_2S) ? `BLAKE_R2_2S : `BLAKE_R2_2B;
        r3 = (md == MODE_2S) ? `BLAKE_R3_2S : `BLAKE_R3_2B;
        r4 = (md == MODE_2S) ? `BLAKE_R4_2S : `BLAKE_R4_2B;
        v[a] = trim(md, v[a] + v[b] + x);
        v[d] = rotr(md, v[d] ^ v[a], r1);
        v[c] = trim(md, v[c] + v[d]);
        v[b] = rotr(md, v[b] ^ v[c], r2);
        v[a] = trim(md, v[a] + v[b] + y);
        v[d] = rotr(md, v[d] ^ v[a], r3);
        v[c] = trim(md, v[c] + v[d]);
        v[b] = rotr(md, v[b] ^ v[c], r4);
        return v;
    endfunction

    function automatic hvec_t compress(input hash_mode_t md, input hvec_t h, input vvec_t m,
                                       input word_t t, input logic f);
        vvec_t v;
        hvec_t res;
        int    rounds;
        int    s;
        rounds = (md == MODE_2S) ? `BLAKE_ROUNDS_2S : `BLAKE_ROUNDS_2B;
        for (int i = 0; i < 8; i++) begin
            v[i]     = trim(md, h[i]);
            v[i + 8] = (md == MODE_2S) ? {32'h0, iv[i][63:32]} : iv[i];
        end
        // Byte counter t0/t1; 2B keeps its upper counter word at zero
        if (md == MODE_2S) begin
            v[12] = v[12] ^ {32'h0, t[31:0]};
            v[13] = v[13] ^ {32'h0, t[63:32]};
        end else begin
            v[12] = v[12] ^ t;
        end
        if (f) begin
            v[14] = trim(md, ~v[14]);
        end
        for (int r = 0; r < rounds; r++) begin
            s = r % 10;
            // Columns
            for (int i = 0; i < 4; i++) begin
                v = mix(md, v, i, 4 + i, 8 + i, 12 + i,
                        m[sigma_tab[s][2 * i]], m[sigma_tab[s][2 * i + 1]]);
            end
            // Diagonals
            for (int i = 0; i < 4; i++) begin
                v = mix(md, v, i, 4 + (i + 1) % 4, 8 + (i + 2) % 4, 12 + (i + 3) % 4,
                        m[sigma_tab[s][8 + 2 * i]], m[sigma_tab[s][9 + 2 * i]]);
            end
        end
        for (int i = 0; i < 8; i++) begin
            res[i] = trim(md, h[i] ^ v[i] ^ v[i + 8]);
        end
        return res;
    endfunction

    assign h_exp = compress(mode, h_in, msg, offset, last);

endmodule

`default_nettype wire

//--- bench/blake_tb.sv
`default_nettype none

module blake_tb
    import blake_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // 40 blocks of up to 200 cycles plus slack
    localparam int max_cycles = 40 * 200 + 2000;
    localparam int lat_2s = 162;
    localparam int lat_2b = 194;

    logic       clk;
    logic       reset;
    hash_mode_t mode;
    logic       start;
    logic       last;
    word_t      offset;
    logic       msg_wr;
    vidx_t      msg_idx;
    word_t      msg_word;
    logic       h_wr;
    hidx_t      h_idx;
    word_t      h_word;
    logic       busy;
    logic       done;
    hvec_t      h_out;

    // Model inputs and its expected chaining value
    hash_mode_t ref_mode;
    hvec_t      ref_h;
    vvec_t      ref_msg;
    word_t      ref_offset;
    logic       ref_last;
    hvec_t      ref_out;

    integer seed;
    int     cycles = 0;
    int     errors;
    int     checks;
    int     test_errors;
    hvec_t  chain_h;
    hvec_t  abc_h;
    hvec_t  abc_digest;
    vvec_t  abc_msg;

    blake_core u_blake_core (
        .clk      (clk),
        .reset    (reset),
        .mode     (mode),
        .start    (start),
        .last     (last),
        .offset   (offset),
        .msg_wr   (msg_wr),
        .msg_idx  (msg_idx),
        .msg_word (msg_word),
        .h_wr     (h_wr),
        .h_idx    (h_idx),
        .h_word   (h_word),
        .busy     (busy),
        .done     (done),
        .h_out    (h_out)
    );

    blake_model u_model (
        .mode   (ref_mode),
        .h_in   (ref_h),
        .msg    (ref_msg),
        .offset (ref_offset),
        .last   (ref_last),
        .h_exp  (ref_out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic hvec_t rand_h();
        hvec_t h;
        for (int i = 0; i < 8; i++) begin
            h[i] = rand_word();
        end
        return h;
    endfunction

    function automatic vvec_t rand_block();
        vvec_t m;
        for (int i = 0; i < 16; i++) begin
            m[i] = rand_word();
        end
        return m;
    endfunction

    task automatic check_hvec(input string what, input hvec_t got, input hvec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            for (int i = 0; i < 8; i++) begin
                if (got[i] !== exp[i]) begin
                    $display("Fail at %0t ns: %s word %0d is %h, expected %h",
                             $time, what, i, got[i], exp[i]);
                end
            end
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // Host writes one word per clock
    task automatic load_msg(input vvec_t m);
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            msg_wr   = 1'b1;
            msg_idx  = vidx_t'(i);
            msg_word = m[i];
        end
        @(posedge clk);
        #1;
        msg_wr = 1'b0;
    endtask

    task automatic load_h(input hvec_t h);
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            h_wr   = 1'b1;
            h_idx  = hidx_t'(i);
            h_word = h[i];
        end
        @(posedge clk);
        #1;
        h_wr = 1'b0;
    endtask

    // Pulse start and count edges until done while watching busy
    task automatic run_block(input hash_mode_t md, input word_t off, input logic lst,
                             input bit noise);
        int n;
        int lat;
        lat = (md == MODE_2S) ? lat_2s : lat_2b;
        @(posedge clk);
        #1;
        mode   = md;
        offset = off;
        last   = lst;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (noise) begin
            // Mode, offset and last change right after the capture edge
            mode   = (md == MODE_2S) ? MODE_2B : MODE_2S;
            offset = ~off;
            last   = ~lst;
        end
        check_flag("busy after start", busy, 1'b1);
        n = 0;
        while (!done) begin
            @(posedge clk);
            #1;
            n++;
            start  = 1'b0;
            msg_wr = 1'b0;
            h_wr   = 1'b0;
            if (noise && n == 40) begin
                // Second start and host writes mid-block that the DUT drops
                start    = 1'b1;
                msg_wr   = 1'b1;
                msg_idx  = vidx_t'($random(seed));
                msg_word = rand_word();
                h_wr     = 1'b1;
                h_idx    = hidx_t'($random(seed));
                h_word   = rand_word();
            end
            if (!done) begin
                check_flag("busy during block", busy, 1'b1);
            end
        end
        check_latency("start to done", n, lat);
        check_flag("busy at done", busy, 1'b0);
        @(posedge clk);
        #1;
        check_flag("done one cycle later", done, 1'b0);
    endtask

    // Load, hash and compare one block against the model
    task automatic hash_block(input string what, input hash_mode_t md, input hvec_t h,
                              input bit reload, input vvec_t m, input word_t off,
                              input logic lst, input bit noise);
        if (reload) begin
            load_h(h);
        end
        load_msg(m);
        ref_mode   = md;
        ref_h      = h;
        ref_msg    = m;
        ref_offset = off;
        ref_last   = lst;
        run_block(md, off, lst, noise);
        check_hvec(what, h_out, ref_out);
        chain_h = ref_out;
    endtask

    // Two to four blocks on one chaining value
    task automatic chain_blocks(input hash_mode_t md);
        logic [31:0] r;
        int          nblk;
        word_t       off;
        hvec_t       h;
        r    = $random(seed);
        nblk = 2 + int'(r % 3);
        h    = rand_h();
        off  = '0;
        for (int b = 0; b < nblk; b++) begin
            off = off + ((md == MODE_2S) ? 64'd64 : 64'd128);
            hash_block("chained h_out", md, h, b == 0, rand_block(), off, b == nblk - 1, 1'b0);
            h = chain_h;
        end
    endtask

    initial begin
        seed       = 32'h36f0;
        errors     = 0;
        checks     = 0;
        test_errors = 0;
        reset      = 1'b1;
        mode       = MODE_2S;
        start      = 1'b0;
        last       = 1'b0;
        offset     = '0;
        msg_wr     = 1'b0;
        msg_idx    = '0;
        msg_word   = '0;
        h_wr       = 1'b0;
        h_idx      = '0;
        h_word     = '0;
        ref_mode   = MODE_2S;
        ref_h      = '0;
        ref_msg    = '0;
        ref_offset = '0;
        ref_last   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        check_flag("busy after reset", busy, 1'b0);
        check_flag("done after reset", done, 1'b0);
        check_hvec("h_out after reset", h_out, '0);
        end_test("1 reset state");

        // BLAKE2s-256 parameter block folded into the IV; "abc" in word 0
        abc_h = {64'h6b08e647, 64'hbb67ae85, 64'h3c6ef372, 64'ha54ff53a,
                 64'h510e527f, 64'h9b05688c, 64'h1f83d9ab, 64'h5be0cd19};
        abc_digest = {64'h8c5e8c50, 64'he2147c32, 64'ha32ba7e1, 64'h2f45eb4e,
                      64'h208b4537, 64'h293ad69e, 64'h4c9b994d, 64'h82596786};
        abc_msg    = '0;
        abc_msg[0] = 64'h0000_0000_0063_6261;
        hash_block("abc h_out", MODE_2S, abc_h, 1'b1, abc_msg, 64'd3, 1'b1, 1'b0);
        check_hvec("abc known digest", h_out, abc_digest);
        end_test("2 BLAKE2s abc");

        for (int i = 0; i < 12; i++) begin
            hash_block("2b random h_out", MODE_2B, rand_h(), 1'b1, rand_block(),
                       rand_word(), rand_bit(), 1'b0);
        end
        end_test("3 BLAKE2b random blocks");

        chain_blocks(MODE_2S);
        chain_blocks(MODE_2B);
        end_test("4 chaining");

        // One block per mode with its start to done count taken in run_block
        hash_block("2s latency h_out", MODE_2S, rand_h(), 1'b1, rand_block(),
                   rand_word(), rand_bit(), 1'b0);
        hash_block("2b latency h_out", MODE_2B, rand_h(), 1'b1, rand_block(),
                   rand_word(), rand_bit(), 1'b0);
        end_test("5 latency");

        for (int i = 0; i < 2; i++) begin
            hash_block("2s busy inputs h_out", MODE_2S, rand_h(), 1'b1, rand_block(),
                       rand_word(), rand_bit(), 1'b1);
            hash_block("2b busy inputs h_out", MODE_2B, rand_h(), 1'b1, rand_block(),
                       rand_word(), rand_bit(), 1'b1);
        end
        end_test("6 inputs while busy");

        $display("Checks: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/blake_core.sv
`default_nettype none

module blake_core
    import blake_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  hash_mode_t mode,
    input  logic       start,
    input  logic       last,
    input  word_t      offset,
    input  logic       msg_wr,
    input  vidx_t      msg_idx,
    input  word_t      msg_word,
    input  logic       h_wr,
    input  hidx_t      h_idx,
    input  word_t      h_word,
    output logic       busy,
    output logic       done,
    output hvec_t      h_out
);

    logic       init_pulse;
    logic       step_en;
    logic       half;
    logic       fold_pulse;
    logic       last_q;
    vsel_t      vsel;
    vidx_t      msg_sel;
    hash_mode_t mode_q;
    word_t      offset_q;
    word_t      msg_rd;
    gvec_t      gin;
    gvec_t      gout;
    hvec_t      h;
    vvec_t      v_all;

    // Message words for the current block
    blake_msg_buf u_msg_buf (
        .clk      (clk),
        .reset    (reset),
        .msg_wr   (msg_wr),
        .msg_idx  (msg_idx),
        .msg_word (msg_word),
        .busy     (busy),
        .msg_sel  (msg_sel),
        .msg_rd   (msg_rd)
    );

    // Round sequencer, also holds mode, last and offset
    blake_round_ctrl u_round_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .mode       (mode),
        .last       (last),
        .offset     (offset),
        .busy       (busy),
        .done       (done),
        .init_pulse (init_pulse),
        .step_en    (step_en),
        .half       (half),
        .vsel       (vsel),
        .msg_sel    (msg_sel),
        .mode_q     (mode_q),
        .fold_pulse (fold_pulse),
        .last_q     (last_q),
        .offset_q   (offset_q)
    );

    blake_gfunc u_gfunc (
        .gin  (gin),
        .msg  (msg_rd),
        .half (half),
        .mode (mode_q),
        .gout (gout)
    );

    blake_vbank u_vbank (
        .clk        (clk),
        .reset      (reset),
        .init_pulse (init_pulse),
        .h          (h),
        .offset     (offset_q),
        .last       (last_q),
        .mode       (mode_q),
        .step_en    (step_en),
        .vsel       (vsel),
        .gout       (gout),
        .gin        (gin),
        .v_all      (v_all)
    );

    // Chaining value, carried across blocks
    blake_hstate u_hstate (
        .clk        (clk),
        .reset      (reset),
        .h_wr       (h_wr),
        .h_idx      (h_idx),
        .h_word     (h_word),
        .busy       (busy),
        .fold_pulse (fold_pulse),
        .v_all      (v_all),
        .mode       (mode_q),
        .h          (h),
        .h_out      (h_out)
    );

endmodule

`default_nettype wire

//--- logic/blake_defs.svh
`ifndef BLAKE_DEFS_SVH
`define BLAKE_DEFS_SVH

// Rounds per block for each variant
`define BLAKE_ROUNDS_2S 10
`define BLAKE_ROUNDS_2B 12

// Block and chaining sizes in words
`define BLAKE_MSG_WORDS 16
`define BLAKE_H_WORDS   8

// G steps per round, four columns then four diagonals
`define BLAKE_STEPS 8

// BLAKE2s rotate amounts, first pair on half 0, second pair on half 1
`define BLAKE_R1_2S 16
`define BLAKE_R2_2S 12
`define BLAKE_R3_2S 8
`define BLAKE_R4_2S 7

// BLAKE2b rotate amounts
`define BLAKE_R1_2B 32
`define BLAKE_R2_2B 24
`define BLAKE_R3_2B 16
`define BLAKE_R4_2B 63

`endif

//--- logic/blake_gfunc.sv
`default_nettype none

`include "blake_defs.svh"

module blake_gfunc
    import blake_pkg::*;
(
    input  gvec_t      gin,
    input  word_t      msg,
    input  logic       half,
    input  hash_mode_t mode,
    output gvec_t      gout
);

    logic  is32;
    word_t a_sum;
    word_t a0;
    word_t d0;
    word_t d1;
    word_t c_sum;
    word_t c0;
    word_t b0;
    word_t b1;

    function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic logic [63:0] ror64(input logic [63:0] x, input int n);
        return (x >> n) | (x << (64 - n));
    endfunction

    assign is32 = (mode == MODE_2S);

    // a = a + b + m
    assign a_sum = gin[0] + gin[1] + msg;
    assign a0    = is32 ? {32'h0, a_sum[31:0]} : a_sum;

    // d = (d ^ a) >>> 16/8 or 32/16
    assign d0 = gin[3] ^ a0;
    assign d1 = is32 ?
        {32'h0, ror32(d0[31:0], half ? `BLAKE_R3_2S : `BLAKE_R1_2S)} :
        ror64(d0, half ? `BLAKE_R3_2B : `BLAKE_R1_2B);

    // c = c + d
    assign c_sum = gin[2] + d1;
    assign c0    = is32 ? {32'h0, c_sum[31:0]} : c_sum;

    // b = (b ^ c) >>> 12/7 or 24/63
    assign b0 = gin[1] ^ c0;
    assign b1 = is32 ?
        {32'h0, ror32(b0[31:0], half ? `BLAKE_R4_2S : `BLAKE_R2_2S)} :
        ror64(b0, half ? `BLAKE_R4_2B : `BLAKE_R2_2B);

    assign gout = {a0, b1, c0, d1};

endmodule

`default_nettype wire

//--- logic/blake_hstate.sv
`default_nettype none

`include "blake_defs.svh"

module blake_hstate
    import blake_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       h_wr,
    input  hidx_t      h_idx,
    input  word_t      h_word,
    input  logic       busy,
    input  logic       fold_pulse,
    input  vvec_t      v_all,
    input  hash_mode_t mode,
    output hvec_t      h,
    output hvec_t      h_out
);

    hvec_t fold_h;

    // h ^ low half ^ high half of the working vector
    always_comb begin
        word_t f;
        for (int i = 0; i < `BLAKE_H_WORDS; i++) begin
            f = h[i] ^ v_all[i] ^ v_all[i + `BLAKE_H_WORDS];
            fold_h[i] = (mode == MODE_2S) ? {32'h0, f[31:0]} : f;
        end
    end

    // Fold wins, host may only load between blocks
    always_ff @(posedge clk) begin
        if (reset) begin
            h     <= '0;
            h_out <= '0;
        end else if (fold_pulse) begin
            h     <= fold_h;
            h_out <= fold_h;
        end else if (h_wr && !busy) begin
            h[h_idx] <= h_word;
        end
    end

endmodule

`default_nettype wire

//--- logic/blake_msg_buf.sv
`default_nettype none

`include "blake_defs.svh"

module blake_msg_buf
    import blake_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  msg_wr,
    input  vidx_t msg_idx,
    input  word_t msg_word,
    input  logic  busy,
    input  vidx_t msg_sel,
    output word_t msg_rd
);

    // One block of message words
    word_t mem [0:`BLAKE_MSG_WORDS-1];

    // Host port, frozen while a block is hashed
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BLAKE_MSG_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (msg_wr && !busy) begin
            mem[msg_idx] <= msg_word;
        end
    end

    // Sigma-selected word straight to the G unit
    assign msg_rd = mem[msg_sel];

endmodule

`default_nettype wire

//--- logic/blake_pkg.sv
`default_nettype none

`include "blake_defs.svh"

package blake_pkg;

    // Variant selected per block
    typedef enum logic {
        MODE_2S = 1'b0,
        MODE_2B = 1'b1
    } hash_mode_t;

    // One state or message word; BLAKE2s keeps it in the low half
    typedef logic [63:0] word_t;

    // Index into the working vector or the message buffer
    typedef logic [3:0] vidx_t;

    // Index of a chaining word
    typedef logic [2:0] hidx_t;

    // a, b, c, d indices of one G step, a in the top nibble
    typedef vidx_t [0:3] vsel_t;

    // a, b, c, d word tuple
    typedef word_t [0:3] gvec_t;

    // Chaining value
    typedef word_t [0:`BLAKE_H_WORDS-1] hvec_t;

    // Full working vector
    typedef word_t [0:`BLAKE_MSG_WORDS-1] vvec_t;

    // BLAKE2b IV, upper halves give the BLAKE2s IV
    localparam hvec_t blake_iv = {
        64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b,
        64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
        64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
        64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
    };

endpackage

`default_nettype wire

//--- logic/blake_round_ctrl.sv
`default_nettype none

`include "blake_defs.svh"

module blake_round_ctrl
    import blake_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  hash_mode_t mode,
    input  logic       last,
    input  word_t      offset,
    output logic       busy,
    output logic       done,
    output logic       init_pulse,
    output logic       step_en,
    output logic       half,
    output vsel_t      vsel,
    output vidx_t      msg_sel,
    output hash_mode_t mode_q,
    output logic       fold_pulse,
    output logic       last_q,
    output word_t      offset_q
);

    logic        start_ok;
    logic [3:0]  round;
    logic [2:0]  step;
    logic [3:0]  round_last;
    logic        last_half;
    logic [3:0]  sig_row;
    logic [3:0]  sig_pos;
    logic [63:0] sig_bits;

    // Sigma permutation rows, position 0 in the top nibble
    function automatic logic [63:0] sigma_row(input logic [3:0] row);
        case (row)
            4'd0:    return 64'h0123456789abcdef;
            4'd1:    return 64'hea489fd61c02b753;
            4'd2:    return 64'hb8c052fdae367194;
            4'd3:    return 64'h7931dcbe265a40f8;
            4'd4:    return 64'h905724afe1bc683d;
            4'd5:    return 64'h2c6a0b834d75fe19;
            4'd6:    return 64'hc51fed4a0763928b;
            4'd7:    return 64'hdb7ec13950f4862a;
            4'd8:    return 64'h6fe9b308c2d714a5;
            default: return 64'ha2847615fb9e3cd0;
        endcase
    endfunction

    // Start is only honoured from idle
    assign start_ok = start && !busy;

    assign round_last = (mode_q == MODE_2B) ? 4'(`BLAKE_ROUNDS_2B - 1) :
                                              4'(`BLAKE_ROUNDS_2S - 1);

    // Final half-step of the final round
    assign last_half = half && (step == 3'(`BLAKE_STEPS - 1)) && (round == round_last);

    // Control flow
    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            init_pulse <= 1'b0;
            step_en    <= 1'b0;
            fold_pulse <= 1'b0;
            round      <= '0;
            step       <= '0;
            half       <= 1'b0;
            mode_q     <= MODE_2S;
            last_q     <= 1'b0;
        end else begin
            // E0 -> load, load -> steps, last step -> fold, fold -> done
            init_pulse <= start_ok;
            fold_pulse <= step_en && last_half;
            done       <= fold_pulse;
            if (init_pulse) begin
                step_en <= 1'b1;
            end else if (step_en && last_half) begin
                step_en <= 1'b0;
            end
            if (start_ok) begin
                busy   <= 1'b1;
                mode_q <= mode;
                last_q <= last;
                round  <= '0;
                step   <= '0;
                half   <= 1'b0;
            end else begin
                if (fold_pulse) begin
                    busy <= 1'b0;
                end
                // Half toggles every edge, step wraps into the next round
                if (step_en) begin
                    half <= ~half;
                    if (half) begin
                        step <= step + 3'd1;
                        if (step == 3'(`BLAKE_STEPS - 1)) begin
                            round <= round + 4'd1;
                        end
                    end
                end
            end
        end
    end

    // Block counter, held for the whole block
    always_ff @(posedge clk) begin
        if (start_ok) begin
            offset_q <= offset;
        end
    end

    // Columns first, then diagonals
    always_comb begin
        case (step)
            3'd0:    vsel = 16'h048c;
            3'd1:    vsel = 16'h159d;
            3'd2:    vsel = 16'h26ae;
            3'd3:    vsel = 16'h37bf;
            3'd4:    vsel = 16'h05af;
            3'd5:    vsel = 16'h16bc;
            3'd6:    vsel = 16'h278d;
            default: vsel = 16'h349e;
        endcase
    end

    // Schedule repeats every ten rounds
    assign sig_row  = (round >= 4'd10) ? round - 4'd10 : round;
    assign sig_pos  = {step, half};
    assign sig_bits = sigma_row(sig_row);
    assign msg_sel  = sig_bits[(4'd15 - sig_pos) * 4 +: 4];

endmodule

`default_nettype wire

//--- logic/blake_vbank.sv
`default_nettype none

`include "blake_defs.svh"

module blake_vbank
    import blake_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       init_pulse,
    input  hvec_t      h,
    input  word_t      offset,
    input  logic       last,
    input  hash_mode_t mode,
    input  logic       step_en,
    input  vsel_t      vsel,
    input  gvec_t      gout,
    output gvec_t      gin,
    output vvec_t      v_all
);

    logic  is32;
    vvec_t v;
    vvec_t init_v;
    vvec_t step_v;

    assign is32 = (mode == MODE_2S);

    // Start-of-block vector
    always_comb begin
        for (int i = 0; i < `BLAKE_H_WORDS; i++) begin
            init_v[i] = is32 ? {32'h0, h[i][31:0]} : h[i];
            init_v[i + `BLAKE_H_WORDS] = is32 ? {32'h0, blake_iv[i][63:32]} : blake_iv[i];
        end
        if (is32) begin
            // 64-bit counter split over words 12 and 13
            init_v[12] = init_v[12] ^ {32'h0, offset[31:0]};
            init_v[13] = init_v[13] ^ {32'h0, offset[63:32]};
            if (last) begin
                init_v[14] = init_v[14] ^ 64'h0000_0000_ffff_ffff;
            end
        end else begin
            // Upper counter word stays zero
            init_v[12] = init_v[12] ^ offset;
            if (last) begin
                init_v[14] = ~init_v[14];
            end
        end
    end

    // Per-index write of the four G results
    always_comb begin
        step_v = v;
        for (int k = 0; k < 4; k++) begin
            step_v[vsel[k]] = gout[k];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v <= '0;
        end else if (init_pulse) begin
            v <= init_v;
        end else if (step_en) begin
            v <= step_v;
        end
    end

    // Operand fetch for the current half-step
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            gin[k] = v[vsel[k]];
        end
    end

    assign v_all = v;

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/blake_pkg.sv
logic/blake_msg_buf.sv
logic/blake_round_ctrl.sv
logic/blake_gfunc.sv
logic/blake_vbank.sv
logic/blake_hstate.sv
logic/blake_core.sv
bench/blake_model.sv
bench/blake_tb.sv
